// File: dv/nocArbTb.sv
`include "nocArb_cfg.svh"

module nocArbTb
  import nocArbPkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SCENARIO_CYCLES = 400;  // reset, single, priority, rotation, timeout, random
  localparam int TIMEOUT_CYCLES  = 3 * SCENARIO_CYCLES;

  logic      clk;
  logic      rst;
  flitWord_t flitIn [`PORTS];
  grantVec_t validIn;
  flitWord_t outFlit;
  logic      outValid;
  grantVec_t outSrc;
  grantVec_t grant;

  string       testName = "reset";
  int          cycleCnt = 0;
  int unsigned mState   = 0;  // 0 is idle and holder port + 1 otherwise
  pktLength_t  mTenure  = '0;
  pktLength_t  mLen [`PORTS];
  flitWord_t   mOutFlit = '0;
  logic        mOutValid = 1'b0;
  grantVec_t   mOutSrc  = '0;
  grantVec_t   mGrant;

  nocArbTop DUT (
    .clk      (clk),
    .rst      (rst),
    .lFlit    (flitIn[0]),
    .nFlit    (flitIn[1]),
    .eFlit    (flitIn[2]),
    .wFlit    (flitIn[3]),
    .sFlit    (flitIn[4]),
    .lValid   (validIn[0]),
    .nValid   (validIn[1]),
    .eValid   (validIn[2]),
    .wValid   (validIn[3]),
    .sValid   (validIn[4]),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outSrc   (outSrc),
    .grant    (grant)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic grantVec_t grantOf(input int unsigned st);
    grantVec_t g;
    g = '0;
    if (st != 0)
    begin
      g[st-1] = 1'b1;
    end
    return g;
  endfunction

  // walk the ring from start and return the new state or 0 for idle
  function automatic int unsigned firstFrom(input grantVec_t reqs, input int unsigned start);
    int unsigned p;
    for (int unsigned k = 0; k < `PORTS; k++)
    begin
      p = (start + k) % `PORTS;
      if (reqs[p])
      begin
        return p + 1;
      end
    end
    return 0;
  endfunction

  function automatic flitWord_t headerFlit(input pktLength_t len);
    flitWord_t f;
    f = '0;
    f[`FLIT_W-1 -: `ID_W] = `HEADER_ID;
    f[`LEN_W-1:0] = len;
    return f;
  endfunction

  function automatic flitWord_t dataFlit();
    flitWord_t f;
    f = flitWord_t'($urandom);
    f[`FLIT_W-1 -: `ID_W] = flitId_t'($urandom_range(7, 2));  // never a header id
    return f;
  endfunction

  task automatic flagMismatch(input string what, input logic [31:0] expVal,
                              input logic [31:0] actVal);
    $display("[ERROR] %s %s expected 'h%0h actual 'h%0h", testName, what, expVal, actVal);
    $display("TESTBENCH FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic stopRun(input string msg);
    $display("[ERROR] %s: %s", testName, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "check failed");
  endtask

  // drive one cycle of input from a falling edge
  task automatic drivePorts(input grantVec_t vld, input grantVec_t hdr, input pktLength_t len);
    for (int i = 0; i < `PORTS; i++)
    begin
      validIn[i] = vld[i];
      if (hdr[i])
      begin
        flitIn[i] = headerFlit(len);
      end
      else if (vld[i])
      begin
        flitIn[i] = dataFlit();
      end
      else
      begin
        flitIn[i] = '0;
      end
    end
    @(negedge clk);
  endtask

  task automatic waitIdle();
    while (grant != '0)
    begin
      @(negedge clk);
    end
  endtask

  assign mGrant = grantOf(mState);

  // reference model of arbiter, length latches and output register
  always @(posedge clk)
  begin
    int unsigned h;
    flitWord_t   sel;
    sel = '0;
    for (int i = 0; i < `PORTS; i++)
    begin
      if (mGrant[i])
      begin
        sel = flitIn[i];
      end
    end
    if (rst)
    begin
      mState    <= 0;
      mTenure   <= '0;
      mOutValid <= 1'b0;
      mOutSrc   <= '0;
      mOutFlit  <= '0;
      for (int i = 0; i < `PORTS; i++)
      begin
        mLen[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < `PORTS; i++)
      begin
        if (validIn[i] && flitIn[i][`FLIT_W-1 -: `ID_W] == `HEADER_ID)
        begin
          mLen[i] <= flitIn[i][`LEN_W-1:0];
        end
      end
      if (mState == 0)
      begin
        mState  <= firstFrom(validIn, 0);  // fixed order from idle
        mTenure <= '0;
      end
      else
      begin
        h = mState - 1;
        if (validIn[h] && mTenure != mLen[h])
        begin
          mTenure <= mTenure + 1'b1;
        end
        else
        begin
          mState  <= firstFrom(validIn, (h + 1) % `PORTS);  // holder itself comes last
          mTenure <= '0;
        end
      end
      mOutValid <= |(mGrant & validIn);
      mOutSrc   <= mGrant;
      mOutFlit  <= sel;
    end
  end

  always @(posedge clk)
  begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= TIMEOUT_CYCLES)
    begin
      $display("[ERROR] %s: run did not finish within %0d cycles", testName, TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end
  end

  resetQuiet: assert property (@(posedge clk) (rst && cycleCnt > 0) |-> (grant == '0 && !outValid))
    else stopRun("grant or outValid active while reset is held");
  grantMatch: assert property (@(posedge clk) cycleCnt > 0 |-> grant == mGrant)
    else flagMismatch("grant", $sampled(mGrant), $sampled(grant));
  validMatch: assert property (@(posedge clk) cycleCnt > 0 |-> outValid == mOutValid)
    else flagMismatch("outValid", $sampled(mOutValid), $sampled(outValid));
  srcMatch: assert property (@(posedge clk) cycleCnt > 0 |-> outSrc == mOutSrc)
    else flagMismatch("outSrc", $sampled(mOutSrc), $sampled(outSrc));
  flitMatch: assert property (@(posedge clk) (cycleCnt > 0 && mOutValid) |-> outFlit == mOutFlit)
    else flagMismatch("outFlit", $sampled(mOutFlit), $sampled(outFlit));
  grantOneHot: assert property (@(posedge clk) cycleCnt > 0 |-> $onehot0(grant))
    else stopRun("grant has more than one bit set");
  validSrc: assert property (@(posedge clk) (cycleCnt > 0 && outValid) |-> $onehot(outSrc))
    else stopRun("outValid high without a one-hot outSrc");

  initial
  begin
    grantVec_t  mask;
    grantVec_t  hold;
    grantVec_t  vld;
    grantVec_t  hdr;
    pktLength_t n;
    void'($urandom(32'hdc7bed0d));
    rst     = 1'b1;
    validIn = '1;  // requests and headers while in reset are ignored
    for (int i = 0; i < `PORTS; i++)
    begin
      flitIn[i] = headerFlit(12'd9);
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    testName = "single";
    drivePorts(5'b00001, 5'b00001, 12'd20);
    repeat (8) drivePorts(5'b00001, '0, '0);
    drivePorts('0, '0, '0);
    waitIdle();

    testName = "priority";
    repeat (12)
    begin
      mask = grantVec_t'($urandom_range(31, 1));
      repeat (3) drivePorts(mask, '0, '0);
      drivePorts('0, '0, '0);
      waitIdle();
    end

    testName = "rotation";
    drivePorts(5'b11111, 5'b11111, 12'd15);  // long tenures so only release moves the grant
    drivePorts('0, '0, '0);
    waitIdle();
    repeat (6)
    begin
      hold = grantVec_t'($urandom_range(31, 1));
      repeat (2) drivePorts(hold, '0, '0);
      while (hold != '0)
      begin
        hold = hold & ~grant;  // holder lets go
        repeat (2) drivePorts(hold, '0, '0);
      end
      waitIdle();
    end

    testName = "timeout";
    n = pktLength_t'($urandom_range(6, 2));
    drivePorts(5'b00100, 5'b00100, n);
    drivePorts(5'b01100, 5'b01000, 12'd3);
    repeat (4 * (n + 1) + 8) drivePorts(5'b01100, '0, '0);
    drivePorts('0, '0, '0);
    waitIdle();
    drivePorts(5'b10000, 5'b10000, 12'd2);  // lone requester regranted after expiry
    repeat (12) drivePorts(5'b10000, '0, '0);
    drivePorts(5'b10000, 5'b10000, 12'd0);
    repeat (5) drivePorts(5'b10000, '0, '0);
    drivePorts('0, '0, '0);
    waitIdle();

    testName = "random";
    vld = '0;
    repeat (150)
    begin
      vld = vld ^ (grantVec_t'($urandom) & grantVec_t'($urandom));
      hdr = vld & grantVec_t'($urandom) & grantVec_t'($urandom) & grantVec_t'($urandom);
      drivePorts(vld, hdr, pktLength_t'($urandom_range(7, 0)));
    end
    drivePorts('0, '0, '0);
    waitIdle();
    repeat (2) @(negedge clk);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: logic/flitCrossbar.sv
`include "nocArb_cfg.svh"

module flitCrossbar
  import nocArbPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  grantVec_t grant,
  input  flitWord_t lFlit,
  input  flitWord_t nFlit,
  input  flitWord_t eFlit,
  input  flitWord_t wFlit,
  input  flitWord_t sFlit,
  input  logic      lValid,
  input  logic      nValid,
  input  logic      eValid,
  input  logic      wValid,
  input  logic      sValid,
  output flitWord_t outFlit,
  output logic      outValid,
  output grantVec_t outSrc
);

  flitWord_t flitVec [`PORTS];
  grantVec_t validVec;
  flitWord_t selFlit;
  logic      selValid;

  assign flitVec  = '{lFlit, nFlit, eFlit, wFlit, sFlit};
  assign validVec = {sValid, wValid, eValid, nValid, lValid};

  // and-or mux on the one-hot grant, zero when nothing is granted
  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < `PORTS; i++)
    begin
      selFlit = selFlit | (flitVec[i] & {`FLIT_W{grant[i]}});
    end
  end

  assign selValid = |(grant & validVec);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outSrc   <= '0;
    end
    else
    begin
      outValid <= selValid;
      outSrc   <= grant;
    end
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
  end

endmodule

// File: logic/flitDecoder.sv
`include "nocArb_cfg.svh"

module flitDecoder
  import nocArbPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  flitWord_t  flit,
  input  logic       valid,
  output logic       req,
  output pktLength_t pktLen
);

  flitId_t    flitId;
  pktLength_t payload;
  logic       isHeader;

  assign flitId   = flit[`FLIT_W-1 -: `ID_W];  // type id from the top bits
  assign payload  = flit[`LEN_W-1:0];
  assign isHeader = valid && (flitId == `HEADER_ID);

  // the source keeps valid high for as long as it wants the output
  assign req = valid;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktLen <= '0;
    end
    else if (isHeader)
    begin
      pktLen <= payload;  // kept until the next header
    end
  end

endmodule

// File: logic/grantTimer.sv
module grantTimer
  import nocArbPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  pktLength_t pktLen,
  input  logic       runTimer,
  output logic       timesUp
);

  pktLength_t count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (!runTimer)
    begin
      count <= '0;  // restart for the next tenure
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  // count runs 0..pktLen while held, so the holder gets pktLen+1 cycles
  assign timesUp = (count == pktLen);

endmodule

// File: logic/nocArbPkg.sv
`include "nocArb_cfg.svh"

package nocArbPkg;

  typedef logic [`FLIT_W-1:0] flitWord_t;
  typedef logic [`ID_W-1:0]   flitId_t;
  typedef logic [`LEN_W-1:0]  pktLength_t;  // grant tenure in cycles

  // one bit per port, L=0 N=1 E=2 W=3 S=4
  typedef logic [`PORTS-1:0] grantVec_t;

  // holder states follow the port order, so state minus one is the port index
  typedef enum logic [2:0] {
    ARB_IDLE = 3'd0,
    ARB_L    = 3'd1,
    ARB_N    = 3'd2,
    ARB_E    = 3'd3,
    ARB_W    = 3'd4,
    ARB_S    = 3'd5
  } arbState_t;

endpackage

// File: logic/nocArbTop.sv
module nocArbTop
  import nocArbPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  flitWord_t lFlit,
  input  flitWord_t nFlit,
  input  flitWord_t eFlit,
  input  flitWord_t wFlit,
  input  flitWord_t sFlit,
  input  logic      lValid,
  input  logic      nValid,
  input  logic      eValid,
  input  logic      wValid,
  input  logic      sValid,
  output flitWord_t outFlit,
  output logic      outValid,
  output grantVec_t outSrc,
  output grantVec_t grant
);

  logic       lReq;
  logic       nReq;
  logic       eReq;
  logic       wReq;
  logic       sReq;
  pktLength_t lLen;
  pktLength_t nLen;
  pktLength_t eLen;
  pktLength_t wLen;
  pktLength_t sLen;

  flitDecoder decL (.clk(clk), .rst(rst), .flit(lFlit), .valid(lValid), .req(lReq), .pktLen(lLen));
  flitDecoder decN (.clk(clk), .rst(rst), .flit(nFlit), .valid(nValid), .req(nReq), .pktLen(nLen));
  flitDecoder decE (.clk(clk), .rst(rst), .flit(eFlit), .valid(eValid), .req(eReq), .pktLen(eLen));
  flitDecoder decW (.clk(clk), .rst(rst), .flit(wFlit), .valid(wValid), .req(wReq), .pktLen(wLen));
  flitDecoder decS (.clk(clk), .rst(rst), .flit(sFlit), .valid(sValid), .req(sReq), .pktLen(sLen));

  portArbiter arb (
    .clk   (clk),
    .rst   (rst),
    .lReq  (lReq),
    .nReq  (nReq),
    .eReq  (eReq),
    .wReq  (wReq),
    .sReq  (sReq),
    .lLen  (lLen),
    .nLen  (nLen),
    .eLen  (eLen),
    .wLen  (wLen),
    .sLen  (sLen),
    .grant (grant)
  );

  // raw flits go straight to the crossbar, the decoders only feed the arbiter
  flitCrossbar xbar (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .lFlit    (lFlit),
    .nFlit    (nFlit),
    .eFlit    (eFlit),
    .wFlit    (wFlit),
    .sFlit    (sFlit),
    .lValid   (lValid),
    .nValid   (nValid),
    .eValid   (eValid),
    .wValid   (wValid),
    .sValid   (sValid),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outSrc   (outSrc)
  );

endmodule

// File: logic/nocArb_cfg.svh
`ifndef NOCARB_CFG_SVH
`define NOCARB_CFG_SVH

// flit layout: id in the top bits, length in the low bits
`define FLIT_W 16

`define ID_W 3

`define LEN_W 12

// L, N, E, W, S
`define PORTS 5

// type id carried by a header flit
`define HEADER_ID 3'b001

`endif

// File: logic/portArbiter.sv
`include "nocArb_cfg.svh"

module portArbiter
  import nocArbPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       lReq,
  input  logic       nReq,
  input  logic       eReq,
  input  logic       wReq,
  input  logic       sReq,
  input  pktLength_t lLen,
  input  pktLength_t nLen,
  input  pktLength_t eLen,
  input  pktLength_t wLen,
  input  pktLength_t sLen,
  output grantVec_t  grant
);

  arbState_t  state;
  arbState_t  nextState;
  logic [2:0] holderIdx;
  grantVec_t  reqVec;
  grantVec_t  runTimer;
  grantVec_t  timesUp;
  pktLength_t lenVec [`PORTS];

  assign reqVec = {sReq, wReq, eReq, nReq, lReq};
  assign lenVec = '{lLen, nLen, eLen, wLen, sLen};

  assign holderIdx = (state == ARB_IDLE) ? 3'd0 : 3'(state - 3'd1);

  // first requester after start in circular order, start itself checked last
  function automatic arbState_t nextHolder(input grantVec_t reqs, input int unsigned start);
    arbState_t   pick;
    int unsigned idx;
    pick = ARB_IDLE;
    for (int unsigned off = `PORTS; off > 0; off--)
    begin
      idx = (start + off) % `PORTS;
      if (reqs[idx])
      begin
        pick = arbState_t'(3'(idx + 1));  // lower offsets overwrite, so nearest wins
      end
    end
    return pick;
  endfunction

  always_comb
  begin
    nextState = ARB_IDLE;
    runTimer  = '0;
    if (state == ARB_IDLE)
    begin
      nextState = nextHolder(reqVec, `PORTS - 1);  // search from S gives L, N, E, W, S
    end
    else if (reqVec[holderIdx] && !timesUp[holderIdx])
    begin
      nextState           = state;
      runTimer[holderIdx] = 1'b1;
    end
    else
    begin
      nextState = nextHolder(reqVec, holderIdx);  // released or timed out
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= ARB_IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    case (state)
      ARB_L:
      begin
        grant = 5'b00001;
      end
      ARB_N:
      begin
        grant = 5'b00010;
      end
      ARB_E:
      begin
        grant = 5'b00100;
      end
      ARB_W:
      begin
        grant = 5'b01000;
      end
      ARB_S:
      begin
        grant = 5'b10000;
      end
      default:
      begin
        grant = '0;  // idle
      end
    endcase
  end

  for (genvar i = 0; i < `PORTS; i++)
  begin : timerGen
    grantTimer portTimer (
      .clk      (clk),
      .rst      (rst),
      .pktLen   (lenVec[i]),
      .runTimer (runTimer[i]),
      .timesUp  (timesUp[i])
    );
  end

endmodule

// File: run.sh
#!/bin/sh
# build and run the arbiter testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing -Wno-fatal \
  -f vlog.f \
  --top-module nocArbTb \
  -o nocArbSim

# the simulator exits non-zero on failure, so keep going and let the log decide
./obj_dir/nocArbSim 2>&1 | tee sim.log || true

if grep -q "^TESTBENCH PASSED$" sim.log; then
  echo "simulation ok"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: vlog.f
+incdir+logic
logic/nocArbPkg.sv
logic/flitDecoder.sv
logic/grantTimer.sv
logic/portArbiter.sv
logic/flitCrossbar.sv
logic/nocArbTop.sv
dv/nocArbTb.sv
